/* logic/debug_pkg.sv */
package debug_pkg;

    localparam int WORD_W      = 32;
    localparam int REG_COUNT   = 32;
    localparam int REG_ADDR_W  = $clog2(REG_COUNT);
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_IDX_W  = $clog2(DMEM_WORDS);
    localparam int IMEM_WORDS  = 64;
    localparam int IMEM_IDX_W  = $clog2(IMEM_WORDS);
    localparam int LATCH_WORDS = 11;
    localparam int LATCH_IDX_W = $clog2(LATCH_WORDS);
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int TX_CREDITS  = 4;
    localparam int CREDIT_W    = $clog2(TX_CREDITS + 1);

    // host commands, ascii with the first character in the top byte
    localparam logic [WORD_W-1:0] CMD_LOAD   = "\0lom";
    localparam logic [WORD_W-1:0] CMD_CONT   = "\0com";
    localparam logic [WORD_W-1:0] CMD_STEP   = "\0stm";
    localparam logic [WORD_W-1:0] CMD_NEXT   = "nxst";
    localparam logic [WORD_W-1:0] CMD_CANCEL = "clst";
    localparam logic [WORD_W-1:0] END_INSTR  = 32'hffff_ffff;
    localparam logic [WORD_W-1:0] END_DUMP   = "endd";

    typedef struct packed {
        logic [31:0]  instr;
        logic [31:0]  pc;
    } if_id_t; // 64 bits

    typedef struct packed {
        logic [10:0]  ctrl;
        logic [127:0] data;
    } id_ex_t; // 139 bits

    typedef struct packed {
        logic [11:0]  ctrl;
        logic [63:0]  data;
    } ex_mem_t; // 76 bits

    typedef struct packed {
        logic [6:0]   ctrl;
        logic [63:0]  data;
    } mem_wb_t; // 71 bits

    // if_id sits in the low bits so it leaves first in the dump
    typedef struct packed {
        mem_wb_t mem_wb;
        ex_mem_t ex_mem;
        id_ex_t  id_ex;
        if_id_t  if_id;
    } snapshot_t;

    localparam int SNAP_PAD_W = LATCH_WORDS * WORD_W - $bits(snapshot_t);

    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD,
        S_RUN,
        S_STEP,
        S_STEP_EXEC,
        S_DUMP_REGS,
        S_DUMP_LATCH,
        S_DUMP_MEM,
        S_DUMP_END
    } dbg_state_t;

endpackage

/* logic/rx_word_assembler.sv */
`timescale 1ns/1ns

module rx_word_assembler (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic [7:0]                   i_rx_byte,
    input  logic                         i_rx_valid,
    output logic [debug_pkg::WORD_W-1:0] o_word,
    output logic                         o_word_valid
);
    import debug_pkg::*;

    logic [1:0]        byte_cnt;
    logic [WORD_W-1:0] shift_reg;

    // bytes enter at the top and move down, so the first one ends in the lsb
    always_ff @(posedge i_clk) begin
        if (i_rx_valid) begin
            shift_reg <= {i_rx_byte, shift_reg[WORD_W-1:8]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt     <= 2'd0;
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= 1'b0;
            if (i_rx_valid) begin
                byte_cnt <= byte_cnt + 2'd1; // wraps after the fourth byte
                if (byte_cnt == 2'd3) begin
                    o_word_valid <= 1'b1;
                end
            end
        end
    end

    // shift register holds the full word during the valid cycle
    assign o_word = shift_reg;

endmodule

/* logic/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem (
    input  logic                         i_clk,
    input  logic                         i_write,
    input  logic [debug_pkg::WORD_W-1:0] i_write_addr,
    input  logic [debug_pkg::WORD_W-1:0] i_write_data,
    input  logic [debug_pkg::WORD_W-1:0] i_fetch_addr,
    output logic [debug_pkg::WORD_W-1:0] o_fetch_instr
);
    import debug_pkg::*;

    logic [WORD_W-1:0]     mem [IMEM_WORDS];
    logic [IMEM_IDX_W-1:0] write_idx;
    logic [IMEM_IDX_W-1:0] fetch_idx;

    // byte address to word index, upper bits dropped so addresses wrap
    assign write_idx = i_write_addr[IMEM_IDX_W+1:2];
    assign fetch_idx = i_fetch_addr[IMEM_IDX_W+1:2];

    always_ff @(posedge i_clk) begin
        if (i_write) begin
            mem[write_idx] <= i_write_data;
        end
    end

    assign o_fetch_instr = mem[fetch_idx]; // async read for the fetch stage

endmodule

/* logic/debug_unit.sv */
`timescale 1ns/1ns

module debug_unit (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic [debug_pkg::WORD_W-1:0]     i_word,
    input  logic                             i_word_valid,
    input  logic                             i_program_end,
    input  debug_pkg::snapshot_t             i_snapshot,
    input  logic [debug_pkg::WORD_W-1:0]     i_reg_data,
    input  logic [debug_pkg::WORD_W-1:0]     i_dmem_data,
    input  logic                             i_fifo_ready,
    output logic                             o_halt,
    output logic                             o_stall,
    output logic                             o_pipe_reset,
    output logic                             o_imem_write,
    output logic [debug_pkg::WORD_W-1:0]     o_imem_addr,
    output logic [debug_pkg::WORD_W-1:0]     o_imem_data,
    output logic [debug_pkg::REG_ADDR_W-1:0] o_reg_addr,
    output logic [debug_pkg::WORD_W-1:0]     o_dmem_addr,
    output logic                             o_push,
    output logic [debug_pkg::WORD_W-1:0]     o_push_word
);
    import debug_pkg::*;

    dbg_state_t                    state;
    logic                          prog_ready;
    logic                          step_mode; // dump returns to step wait
    logic [1:0]                    end_cnt;
    logic [WORD_W-1:0]             load_addr;
    logic [REG_ADDR_W-1:0]         reg_idx;
    logic [LATCH_IDX_W-1:0]        latch_idx;
    logic [DMEM_IDX_W-1:0]         mem_idx;
    logic                          val_sent;  // value pushed, address still due
    logic [LATCH_WORDS*WORD_W-1:0] snap_flat;
    logic                          accepted;
    logic                          mem_next;

    assign snap_flat   = {{SNAP_PAD_W{1'b0}}, i_snapshot};
    assign o_reg_addr  = reg_idx;
    assign o_dmem_addr = {{(WORD_W-DMEM_IDX_W-2){1'b0}}, mem_idx, 2'b00};
    assign o_stall     = (state == S_RUN) && i_program_end; // hold while the tail drains

    // dump word selection, reads from the pipeline side are combinational
    always_comb begin
        o_push      = 1'b0;
        o_push_word = i_reg_data;
        case (state)
            S_DUMP_REGS: begin
                o_push = 1'b1;
            end
            S_DUMP_LATCH: begin
                o_push      = 1'b1;
                o_push_word = snap_flat[latch_idx*WORD_W +: WORD_W];
            end
            S_DUMP_MEM: begin
                o_push      = val_sent || (i_dmem_data != '0); // zero words are skipped
                o_push_word = val_sent ? o_dmem_addr : i_dmem_data;
            end
            S_DUMP_END: begin
                o_push      = 1'b1;
                o_push_word = END_DUMP;
            end
            default: begin
                o_push = 1'b0;
            end
        endcase
    end

    assign accepted = o_push && i_fifo_ready;
    // move to the next memory word once the pair is out, or right away if zero
    assign mem_next = !o_push || (accepted && val_sent);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= S_IDLE;
            o_halt       <= 1'b1;
            o_pipe_reset <= 1'b0;
            o_imem_write <= 1'b0;
            prog_ready   <= 1'b0;
            step_mode    <= 1'b0;
            end_cnt      <= 2'd0;
            load_addr    <= '0;
            reg_idx      <= '0;
            latch_idx    <= '0;
            mem_idx      <= '0;
            val_sent     <= 1'b0;
        end else begin
            o_pipe_reset <= 1'b0;
            o_imem_write <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_word_valid) begin
                        if (i_word == CMD_LOAD) begin
                            prog_ready <= 1'b0;
                            state      <= S_LOAD;
                        end else if (i_word == CMD_CONT && prog_ready) begin
                            o_halt    <= 1'b0;
                            step_mode <= 1'b0;
                            state     <= S_RUN;
                        end else if (i_word == CMD_STEP && prog_ready) begin
                            step_mode <= 1'b1;
                            state     <= S_STEP;
                        end
                    end
                end
                S_LOAD: begin
                    if (i_word_valid) begin
                        o_imem_write <= 1'b1;
                        o_imem_addr  <= load_addr;
                        o_imem_data  <= i_word; // end marker is stored as well
                        if (i_word == END_INSTR) begin
                            load_addr    <= '0;
                            prog_ready   <= 1'b1;
                            o_pipe_reset <= 1'b1;
                            state        <= S_IDLE;
                        end else begin
                            load_addr <= load_addr + WORD_W'(4);
                        end
                    end
                end
                S_RUN: begin
                    if (i_program_end) begin
                        if (end_cnt == 2'd3) begin
                            o_halt <= 1'b1; // fourth sample, last instruction is out
                            state  <= S_DUMP_REGS;
                        end else begin
                            end_cnt <= end_cnt + 2'd1;
                        end
                    end
                end
                S_STEP: begin
                    if (i_word_valid) begin
                        if (i_word == CMD_NEXT) begin
                            o_halt <= 1'b0;
                            state  <= S_STEP_EXEC;
                        end else if (i_word == CMD_CANCEL) begin
                            o_pipe_reset <= 1'b1;
                            step_mode    <= 1'b0;
                            state        <= S_IDLE;
                        end
                    end
                end
                S_STEP_EXEC: begin
                    o_halt <= 1'b1; // one clock released
                    state  <= S_DUMP_REGS;
                end
                S_DUMP_REGS: begin
                    if (accepted) begin
                        reg_idx <= reg_idx + 1'b1;
                        if (reg_idx == REG_ADDR_W'(REG_COUNT - 1)) begin
                            state <= S_DUMP_LATCH;
                        end
                    end
                end
                S_DUMP_LATCH: begin
                    if (accepted) begin
                        if (latch_idx == LATCH_IDX_W'(LATCH_WORDS - 1)) begin
                            latch_idx <= '0;
                            state     <= S_DUMP_MEM;
                        end else begin
                            latch_idx <= latch_idx + 1'b1;
                        end
                    end
                end
                S_DUMP_MEM: begin
                    if (mem_next) begin
                        val_sent <= 1'b0;
                        mem_idx  <= mem_idx + 1'b1;
                        if (mem_idx == DMEM_IDX_W'(DMEM_WORDS - 1)) begin
                            state <= S_DUMP_END;
                        end
                    end else if (accepted) begin
                        val_sent <= 1'b1;
                    end
                end
                S_DUMP_END: begin
                    if (accepted) begin
                        if (step_mode) begin
                            state <= S_STEP;
                        end else begin
                            o_pipe_reset <= 1'b1;
                            end_cnt      <= 2'd0;
                            state        <= S_IDLE;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/dump_fifo.sv */
`timescale 1ns/1ns

module dump_fifo (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_push,
    input  logic [debug_pkg::WORD_W-1:0] i_push_word,
    input  logic                         i_tx_credit,
    output logic                         o_ready,
    output logic [debug_pkg::WORD_W-1:0] o_tx_word,
    output logic                         o_tx_valid
);
    import debug_pkg::*;

    logic [WORD_W-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic [CREDIT_W-1:0]   credits;
    logic                  wr_en;

    assign o_ready    = (count != (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign wr_en      = i_push && o_ready;
    assign o_tx_valid = (credits != '0) && (count != '0); // a shown word is also popped
    assign o_tx_word  = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_push_word;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CREDIT_W'(TX_CREDITS);
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (o_tx_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !o_tx_valid) begin
                count <= count + 1'b1;
            end else if (!wr_en && o_tx_valid) begin
                count <= count - 1'b1;
            end
            // returned credits saturate at the transmitter window
            if (o_tx_valid && !i_tx_credit) begin
                credits <= credits - 1'b1;
            end else if (!o_tx_valid && i_tx_credit && credits != CREDIT_W'(TX_CREDITS)) begin
                credits <= credits + 1'b1;
            end
        end
    end

endmodule

/* logic/debug_top.sv */
`timescale 1ns/1ns

module debug_top (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic [7:0]                       i_rx_byte,
    input  logic                             i_rx_valid,
    input  logic [debug_pkg::WORD_W-1:0]     i_fetch_addr,
    input  logic                             i_program_end,
    input  debug_pkg::snapshot_t             i_snapshot,
    input  logic [debug_pkg::WORD_W-1:0]     i_reg_data,
    input  logic [debug_pkg::WORD_W-1:0]     i_dmem_data,
    input  logic                             i_tx_credit,
    output logic [debug_pkg::WORD_W-1:0]     o_fetch_instr,
    output logic                             o_halt,
    output logic                             o_stall,
    output logic                             o_pipe_reset,
    output logic [debug_pkg::REG_ADDR_W-1:0] o_reg_addr,
    output logic [debug_pkg::WORD_W-1:0]     o_dmem_addr,
    output logic [debug_pkg::WORD_W-1:0]     o_tx_word,
    output logic                             o_tx_valid
);
    import debug_pkg::*;

    logic [WORD_W-1:0] rx_word;
    logic              rx_word_valid;
    logic              imem_write;
    logic [WORD_W-1:0] imem_addr;
    logic [WORD_W-1:0] imem_data;
    logic              push;
    logic [WORD_W-1:0] push_word;
    logic              fifo_ready;

    rx_word_assembler rx_asm_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_byte    (i_rx_byte),
        .i_rx_valid   (i_rx_valid),
        .o_word       (rx_word),
        .o_word_valid (rx_word_valid)
    );

    debug_unit debug_unit_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_word        (rx_word),
        .i_word_valid  (rx_word_valid),
        .i_program_end (i_program_end),
        .i_snapshot    (i_snapshot),
        .i_reg_data    (i_reg_data),
        .i_dmem_data   (i_dmem_data),
        .i_fifo_ready  (fifo_ready),
        .o_halt        (o_halt),
        .o_stall       (o_stall),
        .o_pipe_reset  (o_pipe_reset),
        .o_imem_write  (imem_write),
        .o_imem_addr   (imem_addr),
        .o_imem_data   (imem_data),
        .o_reg_addr    (o_reg_addr),
        .o_dmem_addr   (o_dmem_addr),
        .o_push        (push),
        .o_push_word   (push_word)
    );

    instr_mem instr_mem_i (
        .i_clk         (i_clk),
        .i_write       (imem_write),
        .i_write_addr  (imem_addr),
        .i_write_data  (imem_data),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_instr (o_fetch_instr)
    );

    dump_fifo dump_fifo_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_push      (push),
        .i_push_word (push_word),
        .i_tx_credit (i_tx_credit),
        .o_ready     (fifo_ready),
        .o_tx_word   (o_tx_word),
        .o_tx_valid  (o_tx_valid)
    );

endmodule

/* test/debug_top_tb.sv */
`timescale 1ns/1ns

module debug_top_tb;
    import debug_pkg::*;

    localparam int PROG_LEN    = 12;
    localparam int END_DELAY   = 6;   // cycles until the modelled program reaches its end
    localparam int MAX_DELAY   = 5;   // host credit return delay
    localparam int HOLD_CYCLES = 100;
    localparam int SNAP_W      = $bits(snapshot_t);
    localparam int FLAT_W      = LATCH_WORDS * WORD_W;
    localparam int DUMP_MAX    = REG_COUNT + LATCH_WORDS + 2 * DMEM_WORDS + 1;
    localparam int DUMP_LIMIT  = DUMP_MAX * (MAX_DELAY + 2) + HOLD_CYCLES + 100;
    localparam int RUNS        = 5;
    localparam int WATCHDOG    = RUNS * DUMP_LIMIT + 2000;

    logic                  i_clk;
    logic                  i_reset;
    logic [7:0]            i_rx_byte;
    logic                  i_rx_valid;
    logic [WORD_W-1:0]     i_fetch_addr;
    logic                  i_program_end;
    snapshot_t             i_snapshot;
    logic [WORD_W-1:0]     i_reg_data;
    logic [WORD_W-1:0]     i_dmem_data;
    logic                  i_tx_credit;
    logic [WORD_W-1:0]     o_fetch_instr;
    logic                  o_halt;
    logic                  o_stall;
    logic                  o_pipe_reset;
    logic [REG_ADDR_W-1:0] o_reg_addr;
    logic [WORD_W-1:0]     o_dmem_addr;
    logic [WORD_W-1:0]     o_tx_word;
    logic                  o_tx_valid;

    logic [WORD_W-1:0] reg_model [REG_COUNT];
    logic [WORD_W-1:0] dmem_model [DMEM_WORDS];
    logic [FLAT_W-1:0] snap_bits;
    logic [WORD_W-1:0] prog [PROG_LEN+1];
    logic [WORD_W-1:0] exp_q [$];   // expected dump words in order
    int                delay_q [$]; // one credit delay per word shown
    logic [31:0]       rng;
    logic              loaded;
    logic              hold_credits;
    logic              fetch_chk;
    logic [WORD_W-1:0] fetch_exp;
    int                shown;
    int                returned;
    int                pe_run;
    int                pr_count;
    int                halt_low;
    int                errors;
    int                tests;
    int                passed;
    string             cur_test;

    debug_top dut_i (.*);

    // register file and data memory reads are combinational
    assign i_reg_data  = reg_model[o_reg_addr];
    assign i_dmem_data = dmem_model[o_dmem_addr[DMEM_IDX_W+1:2]];

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    guard_chk: assert property (@(posedge i_clk) disable iff (i_reset)
        !loaded |-> (o_halt && !o_tx_valid))
        else report_error(cur_test, 32'h2, 32'({$sampled(o_halt), $sampled(o_tx_valid)}));
    fetch_cmp: assert property (@(posedge i_clk) disable iff (i_reset)
        fetch_chk |-> (o_fetch_instr == fetch_exp))
        else report_error(cur_test, $sampled(fetch_exp), $sampled(o_fetch_instr));
    stall_chk: assert property (@(posedge i_clk) disable iff (i_reset)
        o_stall == (i_program_end && !o_halt))
        else report_error(cur_test, 32'($sampled(i_program_end && !o_halt)),
                          32'($sampled(o_stall)));
    halt_chk: assert property (@(posedge i_clk) disable iff (i_reset)
        (pe_run >= 4) |-> o_halt)
        else report_error(cur_test, 32'h1, 32'($sampled(o_halt)));
    credit_max: assert property (@(posedge i_clk) disable iff (i_reset)
        (shown - returned) <= TX_CREDITS)
        else report_error(cur_test, TX_CREDITS, $sampled(shown - returned));
    credit_block: assert property (@(posedge i_clk) disable iff (i_reset)
        (shown - returned == TX_CREDITS) |-> !o_tx_valid)
        else report_error(cur_test, 32'h0, 32'($sampled(o_tx_valid)));

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng = x;
        return x;
    endfunction

    task automatic report_error(input string name, input logic [WORD_W-1:0] exp_v,
                                input logic [WORD_W-1:0] act_v);
        $display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
        errors++;
    endtask

    task automatic send_word(input logic [WORD_W-1:0] w);
        for (int b = 0; b < 4; b++) begin
            @(posedge i_clk);
            i_rx_byte  <= w[8*b +: 8]; // low byte goes first
            i_rx_valid <= 1'b1;
        end
        @(posedge i_clk);
        i_rx_valid <= 1'b0;
    endtask

    task automatic fill_models;
        for (int r = 0; r < REG_COUNT; r++) begin
            reg_model[r] = xorshift();
        end
        // roughly a third of the data words are zero and stay out of the dump
        for (int m = 0; m < DMEM_WORDS; m++) begin
            dmem_model[m] = (xorshift() % 3 == 0) ? 32'h0 : xorshift();
        end
        for (int k = 0; k < LATCH_WORDS; k++) begin
            snap_bits[k*WORD_W +: WORD_W] = xorshift();
        end
        snap_bits = FLAT_W'(snap_bits[SNAP_W-1:0]); // pad bits of the last word are zero
        i_snapshot <= snap_bits[SNAP_W-1:0];
    endtask

    task automatic build_dump;
        for (int r = 0; r < REG_COUNT; r++) begin
            exp_q.push_back(reg_model[r]);
        end
        for (int k = 0; k < LATCH_WORDS; k++) begin
            exp_q.push_back(snap_bits[k*WORD_W +: WORD_W]);
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            if (dmem_model[m] != '0) begin
                exp_q.push_back(dmem_model[m]);
                exp_q.push_back(32'(m * 4)); // byte address after its value
            end
        end
        exp_q.push_back(END_DUMP);
    endtask

    task automatic read_program;
        for (int k = 0; k <= PROG_LEN; k++) begin
            @(posedge i_clk);
            i_fetch_addr <= 32'(4 * k);
            fetch_exp    <= prog[k];
            fetch_chk    <= 1'b1;
        end
        @(posedge i_clk);
        fetch_chk <= 1'b0;
    endtask

    task automatic wait_halt_low;
        int n;
        n = 0;
        while (o_halt && n < 10) begin
            @(posedge i_clk);
            n++;
        end
        assert (!o_halt) else begin
            $display("halt did not fall after the run command in test %s", cur_test);
            errors++;
        end
    endtask

    task automatic wait_dump;
        int n;
        n = 0;
        while ((exp_q.size() != 0 || shown != returned) && n < DUMP_LIMIT) begin
            @(posedge i_clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("dump in test %s stopped with %0d words still missing",
                     cur_test, exp_q.size());
            errors++;
        end
    endtask

    task automatic run_cont(input int hold_len);
        int pr0;
        pr0 = pr_count;
        fill_models();
        build_dump();
        hold_credits = (hold_len > 0);
        send_word(CMD_CONT);
        wait_halt_low();
        if (hold_len > 0) begin
            repeat (hold_len) @(posedge i_clk);
            assert (shown - returned == TX_CREDITS)
                else report_error(cur_test, TX_CREDITS, shown - returned);
            hold_credits = 1'b0;
        end
        wait_dump();
        repeat (3) @(posedge i_clk);
        assert (pr_count - pr0 == 1) else report_error(cur_test, 1, pr_count - pr0);
        assert (o_halt) else report_error(cur_test, 1, 32'(o_halt));
    endtask

    task automatic end_test(input int err0);
        tests++;
        if (errors == err0) begin
            passed++;
            $display("test %s passed", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, errors - err0);
        end
    endtask

    // end of program shows up a while after the pipeline is released
    initial begin : pipeline_model
        int run_cnt;
        i_program_end = 1'b0;
        run_cnt = 0;
        forever begin
            @(posedge i_clk);
            if (o_halt !== 1'b0) begin
                run_cnt = 0;
                i_program_end <= 1'b0;
            end else begin
                run_cnt++;
                if (run_cnt >= END_DELAY) i_program_end <= 1'b1;
            end
        end
    end

    initial begin : credit_return
        int d;
        i_tx_credit = 1'b0;
        forever begin
            @(posedge i_clk);
            i_tx_credit <= 1'b0;
            if (!hold_credits && delay_q.size() != 0) begin
                d = delay_q.pop_front();
                repeat (d) @(posedge i_clk);
                i_tx_credit <= 1'b1;
            end
        end
    end

    initial begin : monitor
        logic [WORD_W-1:0] exp_w;
        shown    = 0;
        returned = 0;
        pe_run   = 0;
        pr_count = 0;
        halt_low = 0;
        forever begin
            @(posedge i_clk);
            if (i_reset === 1'b0) begin
                if (o_pipe_reset) pr_count <= pr_count + 1;
                if (!o_halt) halt_low <= halt_low + 1;
                if (i_tx_credit) returned <= returned + 1;
                pe_run <= (i_program_end && !o_halt) ? pe_run + 1 : 0;
                if (o_tx_valid) begin
                    shown <= shown + 1;
                    delay_q.push_back(int'(xorshift() % (MAX_DELAY + 1)));
                    assert (exp_q.size() != 0) else begin
                        $display("unexpected dump word %h in test %s", o_tx_word, cur_test);
                        errors++;
                    end
                    if (exp_q.size() != 0) begin
                        exp_w = exp_q.pop_front();
                        assert (o_tx_word == exp_w) else report_error(cur_test, exp_w, o_tx_word);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge i_clk);
        $display("watchdog ran out after %0d cycles in test %s", WATCHDOG, cur_test);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int err0;
        int pr0;
        int h0;
        int tx0;
        i_reset      = 1'b1;
        i_rx_byte    = 8'h0;
        i_rx_valid   = 1'b0;
        i_fetch_addr = '0;
        i_snapshot   = '0;
        rng          = 32'h5921;
        loaded       = 1'b0;
        hold_credits = 1'b0;
        fetch_chk    = 1'b0;
        fetch_exp    = '0;
        errors       = 0;
        tests        = 0;
        passed       = 0;
        cur_test     = "load";
        fill_models();
        for (int k = 0; k < PROG_LEN; k++) begin
            prog[k] = xorshift();
            if (prog[k] == END_INSTR) prog[k][0] = 1'b0;
        end
        prog[PROG_LEN] = END_INSTR;
        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;

        err0 = errors; // run commands before any load must do nothing
        send_word(CMD_CONT);
        send_word(CMD_STEP);
        repeat (10) @(posedge i_clk);
        pr0 = pr_count;
        send_word(CMD_LOAD);
        for (int k = 0; k <= PROG_LEN; k++) begin
            send_word(prog[k]);
        end
        repeat (4) @(posedge i_clk);
        loaded = 1'b1;
        assert (pr_count - pr0 == 1) else report_error(cur_test, 1, pr_count - pr0);
        read_program();
        end_test(err0);

        cur_test = "continuous";
        err0 = errors;
        run_cont(0);
        end_test(err0);

        cur_test = "step";
        err0 = errors;
        send_word(CMD_STEP);
        repeat (2) begin
            fill_models();
            build_dump();
            h0 = halt_low;
            send_word(CMD_NEXT);
            wait_dump();
            assert (halt_low - h0 == 1) else report_error(cur_test, 1, halt_low - h0);
        end
        pr0 = pr_count;
        tx0 = shown;
        send_word(CMD_CANCEL);
        repeat (20) @(posedge i_clk);
        assert (pr_count - pr0 == 1) else report_error(cur_test, 1, pr_count - pr0);
        assert (shown == tx0) else report_error(cur_test, tx0, shown);
        run_cont(0); // a normal run still works from idle
        end_test(err0);

        cur_test = "credits";
        err0 = errors;
        run_cont(HOLD_CYCLES);
        end_test(err0);

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* debug_top.f */
logic/debug_pkg.sv
logic/rx_word_assembler.sv
logic/instr_mem.sv
logic/debug_unit.sv
logic/dump_fifo.sv
logic/debug_top.sv
test/debug_top_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then scan the log for a failing result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module debug_top_tb \
    -f debug_top.f -o debug_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/debug_sim | tee sim.log \
    && ! grep -q "=== FAIL ===" sim.log \
    || { echo "simulation failed"; exit 1; }
echo "simulation passed"
